// File: Bender.yml
package:
  name: branchPredictor

dependencies: {}

sources:
  # package first, then leaf modules, then the top level
  - bpPkg.sv
  - predTable.sv
  - branchResolveDecode.sv
  - directionTable.sv
  - returnStack.sv
  - nextPcSelect.sv
  - branchPredictor.sv

  # directed testbench, top module tbBranchPredictor
  - target: test
    files:
      - tbBranchPredictor.sv

// File: bpPkg.sv
/*
 * types shared by the next-PC predictor, 32-bit byte addresses, word aligned fetch
 * btb tags hold the full 30-bit word address so entries do not depend on index width
 */
`default_nettype none

package bpPkg;

    // byte address, low two bits are zero for aligned fetch
    typedef logic [31:0] pcT;

    // branch kind as classified by decode in the core
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_COND = 3'd1,
        BR_JUMP = 3'd2,
        BR_CALL = 3'd3,
        BR_RET  = 3'd4
    } brKindT;

    // how one direction counter changes on a resolve
    typedef enum logic [1:0] {
        CNT_HOLD       = 2'd0,
        CNT_INC        = 2'd1,
        CNT_DEC        = 2'd2,
        CNT_SET_STRONG = 2'd3
    } counterOpT;

    // resolved branch record from the execute stage
    typedef struct packed {
        logic   valid;
        pcT     pc;
        brKindT kind;
        logic   taken;
        pcT     target;
    } resolveT;

    // one btb line
    typedef struct packed {
        logic        valid;
        // full word address of the branch
        logic [29:0] tag;
        brKindT      kind;
        // zero for returns, stack top is used instead
        pcT          target;
    } btbEntryT;

endpackage

`default_nettype wire

// File: branchPredictor.f
bpPkg.sv
predTable.sv
branchResolveDecode.sv
directionTable.sv
returnStack.sv
nextPcSelect.sv
branchPredictor.sv
tbBranchPredictor.sv

// File: branchPredictor.sv
/*
 * next-PC predictor, lookup is combinational from fetchPc
 * a resolve trains the tables and RAS at the edge, visible next cycle
 */
`timescale 1ns/1ps
`default_nettype none

module branchPredictor import bpPkg::*; #(
    parameter int INDEX_BITS = 8,
    parameter int RAS_DEPTH  = 32
) (
    input  logic    clk,
    input  logic    resetn,
    input  pcT      fetchPc,
    input  resolveT resolve,
    output pcT      nextPc,
    output logic    predTaken
);

    // decode outputs
    counterOpT counterOp;
    logic      btbWrite;
    btbEntryT  btbWrEntry;
    logic      push;
    pcT        pushValue;
    logic      pop;

    // lookup side
    btbEntryT  btbRdEntry;
    logic      counterTaken;
    pcT        stackTop;
    logic      stackNonEmpty;

    branchResolveDecode i_decode (
        .resolve    (resolve),
        .counterOp  (counterOp),
        .btbWrite   (btbWrite),
        .btbWrEntry (btbWrEntry),
        .push       (push),
        .pushValue  (pushValue),
        .pop        (pop)
    );

    // btb, second read port not needed here
    predTable #(
        .INDEX_BITS (INDEX_BITS),
        .entryT     (btbEntryT)
    ) i_btb (
        .clk      (clk),
        .resetn   (resetn),
        .rdIndex  (fetchPc[INDEX_BITS+1:2]),
        .rdData   (btbRdEntry),
        .rdIndexB (resolve.pc[INDEX_BITS+1:2]),
        .rdDataB  (),
        .wrEnable (btbWrite),
        .wrIndex  (resolve.pc[INDEX_BITS+1:2]),
        .wrData   (btbWrEntry)
    );

    directionTable #(
        .INDEX_BITS (INDEX_BITS)
    ) i_direction (
        .clk          (clk),
        .resetn       (resetn),
        .lookupPc     (fetchPc),
        .predictTaken (counterTaken),
        .updatePc     (resolve.pc),
        .counterOp    (counterOp)
    );

    returnStack #(
        .RAS_DEPTH (RAS_DEPTH)
    ) i_ras (
        .clk       (clk),
        .resetn    (resetn),
        .push      (push),
        .pushValue (pushValue),
        .pop       (pop),
        .top       (stackTop),
        .nonEmpty  (stackNonEmpty)
    );

    nextPcSelect i_select (
        .fetchPc       (fetchPc),
        .btbEntry      (btbRdEntry),
        .counterTaken  (counterTaken),
        .stackTop      (stackTop),
        .stackNonEmpty (stackNonEmpty),
        .nextPc        (nextPc),
        .predTaken     (predTaken)
    );

endmodule

`default_nettype wire

// File: branchResolveDecode.sv
/*
 * purely combinational, one resolve record per cycle at most
 * push and pop are never raised together
 */
`timescale 1ns/1ps
`default_nettype none

module branchResolveDecode import bpPkg::*; (
    input  resolveT   resolve,
    output counterOpT counterOp,
    output logic      btbWrite,
    output btbEntryT  btbWrEntry,
    output logic      push,
    output pcT        pushValue,
    output logic      pop
);

    // return address skips the delay slot
    assign pushValue = resolve.pc + 32'd8;

    always_comb begin
        // defaults, nothing trained
        counterOp  = CNT_HOLD;
        btbWrite   = 1'b0;
        push       = 1'b0;
        pop        = 1'b0;

        // entry content follows the record, write enable decides
        btbWrEntry.valid  = 1'b1;
        btbWrEntry.tag    = resolve.pc[31:2];
        btbWrEntry.kind   = resolve.kind;
        btbWrEntry.target = resolve.target;

        if (resolve.valid) begin
            case (resolve.kind)
                BR_COND: begin
                    counterOp = resolve.taken ? CNT_INC : CNT_DEC;
                    // not-taken branches never allocate
                    btbWrite  = resolve.taken;
                end
                BR_JUMP: begin
                    counterOp = CNT_SET_STRONG;
                    btbWrite  = 1'b1;
                end
                BR_CALL: begin
                    counterOp = CNT_SET_STRONG;
                    btbWrite  = 1'b1;
                    push      = 1'b1;
                end
                BR_RET: begin
                    counterOp = CNT_SET_STRONG;
                    btbWrite  = 1'b1;
                    // target comes from the stack at lookup time
                    btbWrEntry.target = '0;
                    pop       = 1'b1;
                end
                default: begin
                    // BR_NONE or unknown kind
                    counterOp = CNT_HOLD;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: directionTable.sv
/*
 * two-bit saturating counters, 00 strongly not-taken after reset
 * updates are read-modify-write in one cycle on the second read port
 */
`timescale 1ns/1ps
`default_nettype none

module directionTable import bpPkg::*; #(
    parameter int INDEX_BITS = 8
) (
    input  logic      clk,
    input  logic      resetn,
    input  pcT        lookupPc,
    output logic      predictTaken,
    input  pcT        updatePc,
    input  counterOpT counterOp
);

    logic [INDEX_BITS-1:0] lookupIdx;
    logic [INDEX_BITS-1:0] updateIdx;
    logic [1:0]            lookupCnt;
    logic [1:0]            updateCnt;
    logic [1:0]            nextCnt;

    // word index, byte offset dropped
    assign lookupIdx = lookupPc[INDEX_BITS+1:2];
    assign updateIdx = updatePc[INDEX_BITS+1:2];

    predTable #(
        .INDEX_BITS (INDEX_BITS),
        .entryT     (logic [1:0])
    ) i_counters (
        .clk      (clk),
        .resetn   (resetn),
        .rdIndex  (lookupIdx),
        .rdData   (lookupCnt),
        .rdIndexB (updateIdx),
        .rdDataB  (updateCnt),
        .wrEnable (counterOp != CNT_HOLD),
        .wrIndex  (updateIdx),
        .wrData   (nextCnt)
    );

    // saturating step
    always_comb begin
        case (counterOp)
            CNT_INC:        nextCnt = (updateCnt == 2'b11) ? updateCnt : updateCnt + 2'd1;
            CNT_DEC:        nextCnt = (updateCnt == 2'b00) ? updateCnt : updateCnt - 2'd1;
            CNT_SET_STRONG: nextCnt = 2'b11;
            default:        nextCnt = updateCnt;
        endcase
    end

    // upper bit set means weakly or strongly taken
    assign predictTaken = lookupCnt[1];

endmodule

`default_nettype wire

// File: nextPcSelect.sv
/*
 * combinational next-PC choice, fall-through is fetchPc plus 4
 * delay slot handling is left to the fetch stage
 */
`timescale 1ns/1ps
`default_nettype none

module nextPcSelect import bpPkg::*; (
    input  pcT       fetchPc,
    input  btbEntryT btbEntry,
    input  logic     counterTaken,
    input  pcT       stackTop,
    input  logic     stackNonEmpty,
    output pcT       nextPc,
    output logic     predTaken
);

    logic hit;

    // tag is the whole word address
    assign hit = btbEntry.valid && (btbEntry.tag == fetchPc[31:2]);

    always_comb begin
        nextPc    = fetchPc + 32'd4;
        predTaken = 1'b0;
        if (hit) begin
            case (btbEntry.kind)
                BR_JUMP, BR_CALL: begin
                    nextPc    = btbEntry.target;
                    predTaken = 1'b1;
                end
                BR_COND: begin
                    // direction counter decides
                    if (counterTaken) begin
                        nextPc    = btbEntry.target;
                        predTaken = 1'b1;
                    end
                end
                BR_RET: begin
                    // empty stack falls through
                    if (stackNonEmpty) begin
                        nextPc    = stackTop;
                        predTaken = 1'b1;
                    end
                end
                default: begin
                    predTaken = 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: predTable.sv
/*
 * direct-mapped table, two async read ports and one write port
 * reset clears every entry to all zeros, which must mean invalid or idle
 */
`timescale 1ns/1ps
`default_nettype none

module predTable #(
    parameter int  INDEX_BITS = 8,
    parameter type entryT     = logic
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [INDEX_BITS-1:0] rdIndex,
    output entryT                 rdData,
    input  logic [INDEX_BITS-1:0] rdIndexB,
    output entryT                 rdDataB,
    input  logic                  wrEnable,
    input  logic [INDEX_BITS-1:0] wrIndex,
    input  entryT                 wrData
);

    localparam int ENTRIES = 2 ** INDEX_BITS;

    entryT mem [ENTRIES];

    // a write lands at the edge, reads see it next cycle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                mem[i] <= '0;
            end
        end else if (wrEnable) begin
            mem[wrIndex] <= wrData;
        end
    end

    // lookup side
    assign rdData  = mem[rdIndex];
    // second port, used for read-modify-write
    assign rdDataB = mem[rdIndexB];

endmodule

`default_nettype wire

// File: returnStack.sv
/*
 * circular RAS, a push when full overwrites the oldest entry
 * pop on empty is ignored, no recovery on mispredicted calls or returns
 */
`timescale 1ns/1ps
`default_nettype none

module returnStack import bpPkg::*; #(
    parameter int RAS_DEPTH = 32
) (
    input  logic clk,
    input  logic resetn,
    input  logic push,
    input  pcT   pushValue,
    input  logic pop,
    output pcT   top,
    output logic nonEmpty
);

    localparam int PTR_BITS = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(RAS_DEPTH + 1);
    localparam logic [PTR_BITS-1:0] LAST_PTR = PTR_BITS'(RAS_DEPTH - 1);
    localparam logic [CNT_BITS-1:0] FULL_CNT = CNT_BITS'(RAS_DEPTH);

    pcT                  mem [RAS_DEPTH];
    // next free slot
    logic [PTR_BITS-1:0] ptr;
    logic [PTR_BITS-1:0] ptrPrev;
    logic [CNT_BITS-1:0] count;

    // slot below the pointer, wraps to the last entry
    assign ptrPrev = (ptr == '0) ? LAST_PTR : ptr - 1'b1;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ptr   <= '0;
            count <= '0;
        end else if (push) begin
            ptr   <= (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
            // saturates, oldest entry is lost
            count <= (count == FULL_CNT) ? count : count + 1'b1;
        end else if (pop && nonEmpty) begin
            ptr   <= ptrPrev;
            count <= count - 1'b1;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (push) begin
            mem[ptr] <= pushValue;
        end
    end

    assign top      = mem[ptrPrev];
    assign nonEmpty = (count != '0);

endmodule

`default_nettype wire

// File: tbBranchPredictor.sv
/*
 * directed tests for the next-PC predictor with INDEX_BITS 8 and RAS_DEPTH 32
 * the overflow test assumes its call PCs never share the BTB index of RET_PC
 */
`timescale 1ns/1ps
`default_nettype none

module tbBranchPredictor import bpPkg::*; ();

    localparam int   INDEX_BITS    = 8;
    localparam int   RAS_DEPTH     = 32;
    localparam int   RESET_CYCLES  = 8;
    localparam int   PROBE_COUNT   = 8;
    localparam int   CALL_COUNT    = RAS_DEPTH + 1;
    // one cycle per resolve, two per lookup
    localparam int   TEST_CYCLES   = RESET_CYCLES + 2 * PROBE_COUNT + 12 + 10 + 10
                                     + (CALL_COUNT + RAS_DEPTH) + 2 * (RAS_DEPTH + 1);
    localparam int   WATCHDOG_CYCLES = TEST_CYCLES + 64;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic    clk;
    logic    resetn;
    pcT      fetchPc;
    resolveT resolve;
    pcT      nextPc;
    logic    predTaken;

    int          errors;
    int          checks;
    logic [31:0] lfsrState;

    branchPredictor #(
        .INDEX_BITS (INDEX_BITS),
        .RAS_DEPTH  (RAS_DEPTH)
    ) i_dut (
        .clk       (clk),
        .resetn    (resetn),
        .fetchPc   (fetchPc),
        .resolve   (resolve),
        .nextPc    (nextPc),
        .predTaken (predTaken)
    );

    // 8 ns period
    always #4 clk = ~clk;

    // galois lfsr stepped once per bit taken, 30 bits form the word address
    function automatic pcT randPc();
        pcT   value;
        logic bitOut;
        value = '0;
        for (int i = 0; i < 30; i++) begin
            bitOut    = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (bitOut) begin
                lfsrState = lfsrState ^ LFSR_TAPS;
            end
            value = {value[30:0], bitOut};
        end
        return {value[29:0], 2'b00};
    endfunction

    // table index is the low word address bits
    function automatic logic [INDEX_BITS-1:0] indexOf(pcT pc);
        return pc[INDEX_BITS+1:2];
    endfunction

    function automatic resolveT makeResolve(pcT pc, brKindT kind, logic taken, pcT target);
        resolveT r;
        r.valid  = 1'b1;
        r.pc     = pc;
        r.kind   = kind;
        r.taken  = taken;
        r.target = target;
        return r;
    endfunction

    task automatic checkPc(string testName, pcT expected, pcT actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s nextPc: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic checkTaken(string testName, logic expected, logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s predTaken: expected %b, actual %b", testName, expected,
                     actual);
        end
    endtask

    // record is sampled by the DUT at the following edge
    task automatic applyResolve(resolveT r);
        @(posedge clk);
        resolve <= r;
    endtask

    // resolve idles while fetchPc is presented and outputs are read one cycle later
    task automatic lookupCheck(string testName, pcT pc, pcT expPc, logic expTaken);
        @(posedge clk);
        resolve <= '0;
        fetchPc <= pc;
        @(posedge clk);
        checkPc(testName, expPc, nextPc);
        checkTaken(testName, expTaken, predTaken);
    endtask

    task automatic testAfterReset();
        pcT pc;
        for (int i = 0; i < PROBE_COUNT; i++) begin
            pc = randPc();
            lookupCheck("afterReset", pc, pc + 32'd4, 1'b0);
        end
    endtask

    task automatic testCondTraining();
        pcT         br;
        pcT         tgt;
        logic [1:0] cnt;
        logic       outcome [4];
        br  = randPc();
        tgt = randPc();
        // counter starts strongly not-taken
        cnt = 2'b00;
        outcome = '{1'b1, 1'b1, 1'b0, 1'b0};
        for (int i = 0; i < 4; i++) begin
            applyResolve(makeResolve(br, BR_COND, outcome[i], tgt));
            if (outcome[i]) begin
                cnt = (cnt == 2'b11) ? cnt : cnt + 2'd1;
            end else begin
                cnt = (cnt == 2'b00) ? cnt : cnt - 2'd1;
            end
            // upper counter bit selects the stored target
            lookupCheck("condTraining", br, cnt[1] ? tgt : br + 32'd4, cnt[1]);
        end
    endtask

    task automatic testJumpAlias();
        pcT jumpA;
        pcT jumpB;
        pcT tgtA;
        pcT tgtB;
        jumpA = randPc();
        // same index with a tag that differs above the index bits
        jumpB = jumpA ^ (32'h1 << (INDEX_BITS + 2));
        tgtA  = randPc();
        tgtB  = randPc();
        applyResolve(makeResolve(jumpA, BR_JUMP, 1'b1, tgtA));
        lookupCheck("jumpHit", jumpA, tgtA, 1'b1);
        lookupCheck("aliasMiss", jumpB, jumpB + 32'd4, 1'b0);
        applyResolve(makeResolve(jumpB, BR_JUMP, 1'b1, tgtB));
        lookupCheck("aliasReplace", jumpB, tgtB, 1'b1);
        lookupCheck("aliasEvicted", jumpA, jumpA + 32'd4, 1'b0);
    endtask

    // indices 0x40 0x81 and 0xc2 are distinct
    localparam pcT RET_PC  = 32'h0000_2100;
    localparam pcT CALL_A  = 32'h0000_3204;
    localparam pcT CALL_B  = 32'h0000_4308;

    task automatic testCallReturn();
        applyResolve(makeResolve(RET_PC, BR_RET, 1'b1, 32'h0));
        // the return falls through on an empty stack
        lookupCheck("retEmpty", RET_PC, RET_PC + 32'd4, 1'b0);
        applyResolve(makeResolve(CALL_A, BR_CALL, 1'b1, 32'h0001_0000));
        applyResolve(makeResolve(CALL_B, BR_CALL, 1'b1, 32'h0002_0000));
        lookupCheck("retNewest", RET_PC, CALL_B + 32'd8, 1'b1);
        applyResolve(makeResolve(RET_PC, BR_RET, 1'b1, 32'h0));
        lookupCheck("retAfterPop", RET_PC, CALL_A + 32'd8, 1'b1);
    endtask

    task automatic testStackOverflow();
        pcT callPcs [CALL_COUNT];
        pcT pc;
        for (int i = 0; i < CALL_COUNT; i++) begin
            pc = randPc();
            // keep the return entry of RET_PC in the BTB
            if (indexOf(pc) == indexOf(RET_PC)) begin
                pc = pc ^ 32'h4;
            end
            callPcs[i] = pc;
            applyResolve(makeResolve(pc, BR_CALL, 1'b1, randPc()));
        end
        // newest 32 come back in reverse since the oldest was overwritten
        for (int k = 0; k < RAS_DEPTH; k++) begin
            lookupCheck("overflowPop", RET_PC, callPcs[CALL_COUNT-1-k] + 32'd8, 1'b1);
            applyResolve(makeResolve(RET_PC, BR_RET, 1'b1, 32'h0));
        end
        lookupCheck("overflowEmpty", RET_PC, RET_PC + 32'd4, 1'b0);
    endtask

    initial begin
        clk       = 1'b0;
        resetn    = 1'b0;
        fetchPc   = '0;
        resolve   = '0;
        errors    = 0;
        checks    = 0;
        lfsrState = 32'h4d2a;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;

        testAfterReset();
        testCondTraining();
        testJumpAlias();
        testCallReturn();
        testStackOverflow();

        @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // bound on the whole run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
